/* verilog/slave_agent_pkg.sv */
// ----------------------------------------
// slave agent shared types
// ----------------------------------------
`default_nettype none

package slave_agent_pkg;

   // widths that travel on the fabric and on the slave bus
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  byteen_t;
   typedef logic [2:0]  node_id_t;
   typedef logic [1:0]  resp_status_t;

   // response status codes as carried in the response packet
   localparam resp_status_t RESP_OKAY   = 2'b00;
   localparam resp_status_t RESP_SLVERR = 2'b10;

   // low address bits that select a byte lane inside one data word
   localparam int ADDR_LSB = $clog2($bits(byteen_t));

   // the pending record keeps dest id at the bottom, then src id,
   // then the write flag and the synthesize flag on top
   localparam int PEND_DEST_LSB  = 0;
   localparam int PEND_SRC_LSB   = PEND_DEST_LSB + $bits(node_id_t);
   localparam int PEND_WRITE_BIT = PEND_SRC_LSB + $bits(node_id_t);
   localparam int PEND_SYNTH_BIT = PEND_WRITE_BIT + 1;
   localparam int PENDING_W      = PEND_SYNTH_BIT + 1;
   typedef logic [PENDING_W-1:0] pending_entry_t;

   // a read data record holds the slave status above the data word
   localparam int RDATA_W = $bits(resp_status_t) + $bits(data_t);
   typedef logic [RDATA_W-1:0] rdata_entry_t;

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
// ----------------------------------------
// show-ahead synchronous FIFO
// ----------------------------------------
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             push,
   input  wire logic [WIDTH-1:0] push_data,
   input  wire logic             pop,
   output logic                  full,
   output logic                  empty,
   output logic [WIDTH-1:0]      head_data
);

   // pointer index width, the extra top bit marks the wrap
   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW:0]      wr_ptr;
   logic [AW:0]      rd_ptr;
   logic             do_push;
   logic             do_pop;

   // same index with different wrap bits means every slot is in use
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   // requests that would overflow or underflow are dropped here
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // storage array, written at the push edge
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[AW-1:0]] <= push_data;
      end
   end

   // the oldest entry is always presented, so the reader sees it
   // one cycle after it was written
   assign head_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

/* verilog/command_issuer.sv */
// ----------------------------------------
// command decode and slave issue
// ----------------------------------------
`default_nettype none

module command_issuer (
   input  wire logic                            cmd_valid,
   input  wire logic                            cmd_write,
   input  wire logic                            cmd_read,
   input  wire logic                            cmd_posted,
   input  wire slave_agent_pkg::addr_t          cmd_addr,
   input  wire slave_agent_pkg::data_t          cmd_data,
   input  wire slave_agent_pkg::byteen_t        cmd_byteen,
   input  wire slave_agent_pkg::node_id_t       cmd_src_id,
   input  wire slave_agent_pkg::node_id_t       cmd_dest_id,
   output logic                                 cmd_ready,
   output slave_agent_pkg::addr_t               avm_address,
   output slave_agent_pkg::byteen_t             avm_byteenable,
   output logic                                 avm_read,
   output logic                                 avm_write,
   output slave_agent_pkg::data_t               avm_writedata,
   input  wire logic                            avm_waitrequest,
   output logic                                 pend_push,
   output slave_agent_pkg::pending_entry_t      pend_data,
   input  wire logic                            pend_full
);

   import slave_agent_pkg::*;

   logic suppress;
   logic is_read;
   logic is_write;
   logic needs_resp;
   logic slave_ready;

   // --------------------------------------
   // command decode
   // --------------------------------------
   // a command with no byte lane enabled never goes to the slave
   assign suppress = ~|cmd_byteen;

   // a read takes precedence if a packet carries both kinds, so the
   // slave never sees read and write in the same cycle
   assign is_read  = cmd_valid & cmd_read;
   assign is_write = cmd_valid & cmd_write & ~cmd_read;

   // reads and non-posted writes owe an answer to the fabric
   assign needs_resp = is_read | (is_write & ~cmd_posted);

   // suppressed commands ignore the slave, others wait for it
   assign slave_ready = suppress | ~avm_waitrequest;

   // every command stalls while the pending storage is full
   assign cmd_ready = cmd_valid & ~pend_full & slave_ready;

   // --------------------------------------
   // slave side
   // --------------------------------------
   // the full check keeps the slave from taking a command the fabric
   // still holds, which would issue it twice
   assign avm_read  = is_read & ~suppress & ~pend_full;
   assign avm_write = is_write & ~suppress & ~pend_full;

   // the slave only sees word addresses
   assign avm_address    = {cmd_addr[$bits(addr_t)-1:ADDR_LSB], {ADDR_LSB{1'b0}}};
   assign avm_byteenable = cmd_byteen;
   assign avm_writedata  = cmd_data;

   // --------------------------------------
   // pending record
   // --------------------------------------
   assign pend_push = cmd_ready & needs_resp;

   // the agent answers non-posted writes itself, and suppressed reads
   // never produce slave data, so both get the synthesize flag
   always_comb begin
      pend_data = '0;
      pend_data[PEND_SYNTH_BIT] = (is_write & ~cmd_posted) | (is_read & suppress);
      pend_data[PEND_WRITE_BIT] = is_write;
      pend_data[PEND_SRC_LSB +: $bits(node_id_t)]  = cmd_src_id;
      pend_data[PEND_DEST_LSB +: $bits(node_id_t)] = cmd_dest_id;
   end

endmodule

`default_nettype wire

/* verilog/response_builder.sv */
// ----------------------------------------
// response packet builder
// ----------------------------------------
`default_nettype none

module response_builder (
   input  wire logic                            pend_empty,
   input  wire slave_agent_pkg::pending_entry_t pend_head,
   output logic                                 pend_pop,
   input  wire logic                            rdata_empty,
   input  wire slave_agent_pkg::rdata_entry_t   rdata_head,
   output logic                                 rdata_pop,
   output logic                                 rsp_valid,
   input  wire logic                            rsp_ready,
   output logic                                 rsp_write,
   output slave_agent_pkg::resp_status_t        rsp_status,
   output slave_agent_pkg::data_t               rsp_data,
   output slave_agent_pkg::node_id_t            rsp_src_id,
   output slave_agent_pkg::node_id_t            rsp_dest_id
);

   import slave_agent_pkg::*;

   logic         synth;
   logic         rsp_xfer;
   resp_status_t slave_status;
   data_t        slave_data;

   // --------------------------------------
   // head record decode
   // --------------------------------------
   // the record at the head is the oldest command still owed an answer
   assign synth = pend_head[PEND_SYNTH_BIT];

   // split the read data record into status and data
   assign slave_status = rdata_head[RDATA_W-1 -: $bits(resp_status_t)];
   assign slave_data   = rdata_head[$bits(data_t)-1:0];

   // a synthesized answer is ready as soon as its record shows up,
   // a slave read also needs its data entry at the read data head
   assign rsp_valid = ~pend_empty & (synth | ~rdata_empty);

   // --------------------------------------
   // response fields
   // --------------------------------------
   // all fields come from FIFO heads, which only move on a pop, so a
   // stalled response holds steady until rsp_ready returns
   assign rsp_write = pend_head[PEND_WRITE_BIT];

   // synthesized answers are always OKAY with zero data
   assign rsp_status = synth ? RESP_OKAY : slave_status;
   assign rsp_data   = synth ? '0 : slave_data;

   // the answer travels back to the node that sent the command
   assign rsp_src_id  = pend_head[PEND_DEST_LSB +: $bits(node_id_t)];
   assign rsp_dest_id = pend_head[PEND_SRC_LSB +: $bits(node_id_t)];

   // --------------------------------------
   // pops
   // --------------------------------------
   assign rsp_xfer = rsp_valid & rsp_ready;

   // the record leaves on every transfer
   assign pend_pop = rsp_xfer;

   // read data is consumed only by answers that came from the slave
   assign rdata_pop = rsp_xfer & ~synth;

endmodule

`default_nettype wire

/* verilog/slave_agent_top.sv */
// ----------------------------------------
// packet interconnect slave agent
// ----------------------------------------
`default_nettype none

module slave_agent_top #(
   parameter int PENDING_DEPTH = 4
) (
   input  wire logic                         clk,
   input  wire logic                         reset,

   // fabric command channel
   input  wire logic                         cmd_valid,
   output logic                              cmd_ready,
   input  wire logic                         cmd_write,
   input  wire logic                         cmd_read,
   input  wire logic                         cmd_posted,
   input  wire slave_agent_pkg::addr_t       cmd_addr,
   input  wire slave_agent_pkg::data_t       cmd_data,
   input  wire slave_agent_pkg::byteen_t     cmd_byteen,
   input  wire slave_agent_pkg::node_id_t    cmd_src_id,
   input  wire slave_agent_pkg::node_id_t    cmd_dest_id,

   // memory-mapped slave
   output slave_agent_pkg::addr_t            avm_address,
   output slave_agent_pkg::byteen_t          avm_byteenable,
   output logic                              avm_read,
   output logic                              avm_write,
   output slave_agent_pkg::data_t            avm_writedata,
   input  wire logic                         avm_waitrequest,
   input  wire slave_agent_pkg::data_t       avm_readdata,
   input  wire logic                         avm_readdatavalid,
   input  wire slave_agent_pkg::resp_status_t avm_response,

   // fabric response channel
   output logic                              rsp_valid,
   input  wire logic                         rsp_ready,
   output logic                              rsp_write,
   output slave_agent_pkg::resp_status_t     rsp_status,
   output slave_agent_pkg::data_t            rsp_data,
   output slave_agent_pkg::node_id_t         rsp_src_id,
   output slave_agent_pkg::node_id_t         rsp_dest_id
);

   import slave_agent_pkg::*;

   logic           pend_push;
   pending_entry_t pend_push_data;
   logic           pend_full;
   logic           pend_empty;
   pending_entry_t pend_head;
   logic           pend_pop;
   rdata_entry_t   rdata_push_data;
   logic           rdata_empty;
   rdata_entry_t   rdata_head;
   logic           rdata_pop;

   // status sits above the data word in the stored record
   assign rdata_push_data = {avm_response, avm_readdata};

   command_issuer issuer (
      .cmd_valid       (cmd_valid),
      .cmd_write       (cmd_write),
      .cmd_read        (cmd_read),
      .cmd_posted      (cmd_posted),
      .cmd_addr        (cmd_addr),
      .cmd_data        (cmd_data),
      .cmd_byteen      (cmd_byteen),
      .cmd_src_id      (cmd_src_id),
      .cmd_dest_id     (cmd_dest_id),
      .cmd_ready       (cmd_ready),
      .avm_address     (avm_address),
      .avm_byteenable  (avm_byteenable),
      .avm_read        (avm_read),
      .avm_write       (avm_write),
      .avm_writedata   (avm_writedata),
      .avm_waitrequest (avm_waitrequest),
      .pend_push       (pend_push),
      .pend_data       (pend_push_data),
      .pend_full       (pend_full)
   );

   // one record per command that owes an answer, in command order
   sync_fifo #(
      .WIDTH (PENDING_W),
      .DEPTH (PENDING_DEPTH)
   ) pending_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (pend_push),
      .push_data (pend_push_data),
      .pop       (pend_pop),
      .full      (pend_full),
      .empty     (pend_empty),
      .head_data (pend_head)
   );

   // each slave read also holds a pending record, so this FIFO never
   // holds more entries than the pending FIFO and cannot overflow
   sync_fifo #(
      .WIDTH (RDATA_W),
      .DEPTH (PENDING_DEPTH)
   ) rdata_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (avm_readdatavalid),
      .push_data (rdata_push_data),
      .pop       (rdata_pop),
      .full      (),
      .empty     (rdata_empty),
      .head_data (rdata_head)
   );

   response_builder builder (
      .pend_empty  (pend_empty),
      .pend_head   (pend_head),
      .pend_pop    (pend_pop),
      .rdata_empty (rdata_empty),
      .rdata_head  (rdata_head),
      .rdata_pop   (rdata_pop),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_write   (rsp_write),
      .rsp_status  (rsp_status),
      .rsp_data    (rsp_data),
      .rsp_src_id  (rsp_src_id),
      .rsp_dest_id (rsp_dest_id)
   );

endmodule

`default_nettype wire

/* verification/slave_agent_asserts.sv */
// ----------------------------------------
// slave agent protocol assertions
// ----------------------------------------
`default_nettype none

module slave_agent_asserts (
   input wire logic                          clk,
   input wire logic                          reset,
   input wire logic                          avm_read,
   input wire logic                          avm_write,
   input wire logic                          rsp_valid,
   input wire logic                          rsp_ready,
   input wire logic                          rsp_write,
   input wire slave_agent_pkg::resp_status_t rsp_status,
   input wire slave_agent_pkg::data_t        rsp_data,
   input wire slave_agent_pkg::node_id_t     rsp_src_id,
   input wire slave_agent_pkg::node_id_t     rsp_dest_id
);

   // a response that the fabric refuses must stay valid and unchanged
   rsp_hold: assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_write) && $stable(rsp_status)
         && $stable(rsp_data) && $stable(rsp_src_id) && $stable(rsp_dest_id))
      else $error("stalled response changed its fields");

   // the slave bus carries one kind of transfer at a time
   one_avm_op: assert property (@(posedge clk) disable iff (reset)
      !(avm_read && avm_write))
      else $error("avm_read and avm_write high together");

   // both FIFOs are empty in reset, so nothing may be offered
   rsp_quiet: assert property (@(posedge clk) reset |-> !rsp_valid)
      else $error("rsp_valid high during reset");

endmodule

bind slave_agent_top slave_agent_asserts i_asserts (
   .clk         (clk),
   .reset       (reset),
   .avm_read    (avm_read),
   .avm_write   (avm_write),
   .rsp_valid   (rsp_valid),
   .rsp_ready   (rsp_ready),
   .rsp_write   (rsp_write),
   .rsp_status  (rsp_status),
   .rsp_data    (rsp_data),
   .rsp_src_id  (rsp_src_id),
   .rsp_dest_id (rsp_dest_id)
);

`default_nettype wire

/* verification/tb_slave_agent.sv */
// ----------------------------------------
// slave agent testbench
// ----------------------------------------
`default_nettype none

module tb_slave_agent;

   import slave_agent_pkg::*;

   localparam int ACCEPT_LIMIT = 500;
   localparam int DRAIN_LIMIT  = 5000;

   logic         clk;
   logic         reset;
   logic         cmd_valid;
   logic         cmd_ready;
   logic         cmd_write;
   logic         cmd_read;
   logic         cmd_posted;
   addr_t        cmd_addr;
   data_t        cmd_data;
   byteen_t      cmd_byteen;
   node_id_t     cmd_src_id;
   node_id_t     cmd_dest_id;
   addr_t        avm_address;
   byteen_t      avm_byteenable;
   logic         avm_read;
   logic         avm_write;
   data_t        avm_writedata;
   logic         avm_waitrequest;
   data_t        avm_readdata;
   logic         avm_readdatavalid;
   resp_status_t avm_response;
   logic         rsp_valid;
   logic         rsp_ready;
   logic         rsp_write;
   resp_status_t rsp_status;
   data_t        rsp_data;
   node_id_t     rsp_src_id;
   node_id_t     rsp_dest_id;

   // commands as read from the data file
   logic         q_write [$];
   logic         q_posted [$];
   addr_t        q_addr [$];
   data_t        q_data [$];
   byteen_t      q_byteen [$];
   node_id_t     q_src [$];
   node_id_t     q_dest [$];
   logic         wait_stall_en;
   logic         rsp_stall_en;
   logic         stall_on;
   int           seed = 32'hfbad;

   // slave memory and its shadow in the reference model
   data_t        slave_mem [addr_t];
   data_t        shadow_mem [addr_t];

   // two stage read pipeline of the slave model
   logic         p1_valid = 1'b0;
   data_t        p1_data;
   resp_status_t p1_status;
   logic         p2_valid = 1'b0;
   data_t        p2_data;
   resp_status_t p2_status;

   // responses still owed to the fabric, oldest first
   logic         exp_write [$];
   resp_status_t exp_status [$];
   data_t        exp_data [$];
   node_id_t     exp_src [$];
   node_id_t     exp_dest [$];
   int           rsp_count = 0;

   slave_agent_top #(.PENDING_DEPTH(4)) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   // untouched words read back a value built from the whole address
   function automatic data_t fill_word(input addr_t a);
      return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   function automatic addr_t word_of(input addr_t a);
      return {a[31:2], 2'b00};
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input byteen_t be);
      data_t result;
      result = old_word;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            result[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return result;
   endfunction

   function automatic data_t shadow_word(input addr_t a);
      return shadow_mem.exists(word_of(a)) ? shadow_mem[word_of(a)] : fill_word(word_of(a));
   endfunction

   function automatic data_t slave_word(input addr_t a);
      return slave_mem.exists(word_of(a)) ? slave_mem[word_of(a)] : fill_word(word_of(a));
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped after a failed check");
   endtask

   task automatic compare_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_status(input string name, input resp_status_t got,
                               input resp_status_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic verify_id(input string name, input node_id_t got, input node_id_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic match_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // ----------------------------------------
   // data file and command driver
   // ----------------------------------------
   // the first non comment line holds the stall enables and the rest are commands
   task automatic load_commands();
      int          fd;
      int          code;
      string       line;
      logic        header_seen;
      logic [31:0] f_kind;
      logic [31:0] f_posted;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_be;
      logic [31:0] f_src;
      logic [31:0] f_dest;
      header_seen = 1'b0;
      fd = $fopen("verification/slave_agent_testdata.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open the test data file");
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code == 0 || line.substr(0, 0) == "#") begin
            continue;
         end
         if (!header_seen) begin
            code = $sscanf(line, "%h %h", f_kind, f_posted);
            if (code == 2) begin
               wait_stall_en = f_kind[0];
               rsp_stall_en  = f_posted[0];
               header_seen   = 1'b1;
            end
         end else begin
            code = $sscanf(line, "%h %h %h %h %h %h %h", f_kind, f_posted, f_addr, f_data,
                           f_be, f_src, f_dest);
            if (code == 7) begin
               q_write.push_back(f_kind[0]);
               q_posted.push_back(f_posted[0]);
               q_addr.push_back(f_addr);
               q_data.push_back(f_data);
               q_byteen.push_back(f_be[3:0]);
               q_src.push_back(f_src[2:0]);
               q_dest.push_back(f_dest[2:0]);
            end else if (code > 0) begin
               fail_run("a command line in the test data is malformed");
            end
         end
      end
      $fclose(fd);
   endtask

   // the fields stay put until the agent raises cmd_ready
   task automatic send_command(input int idx);
      int waited;
      @(negedge clk);
      cmd_valid   = 1'b1;
      cmd_write   = q_write[idx];
      cmd_read    = ~q_write[idx];
      cmd_posted  = q_posted[idx];
      cmd_addr    = q_addr[idx];
      cmd_data    = q_data[idx];
      cmd_byteen  = q_byteen[idx];
      cmd_src_id  = q_src[idx];
      cmd_dest_id = q_dest[idx];
      waited = 0;
      @(posedge clk);
      while (!cmd_ready) begin
         if (waited == ACCEPT_LIMIT) begin
            fail_run($sformatf("command %0d was not accepted in time", idx));
         end
         waited++;
         @(posedge clk);
      end
   endtask

   // the queue is sampled on the falling edge away from the updates at the rising edge
   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_data.size() != 0) begin
         if (waited == DRAIN_LIMIT) begin
            fail_run("responses still missing after the drain timeout");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   // ----------------------------------------
   // slave and response channel drivers
   // ----------------------------------------
   initial begin
      avm_waitrequest   = 1'b0;
      avm_readdatavalid = 1'b0;
      avm_readdata      = '0;
      avm_response      = RESP_OKAY;
      rsp_ready         = 1'b0;
      forever begin
         @(negedge clk);
         avm_waitrequest   = stall_on && wait_stall_en && (($random(seed) & 3) == 0);
         rsp_ready         = !(stall_on && rsp_stall_en && (($random(seed) & 3) == 0));
         avm_readdatavalid = p2_valid;
         avm_readdata      = p2_valid ? p2_data : '0;
         avm_response      = p2_valid ? p2_status : RESP_OKAY;
      end
   end

   // ----------------------------------------
   // monitor, slave memory and reference model
   // ----------------------------------------
   always @(posedge clk) begin
      if (!reset) begin
         // answers leave in command order, so the oldest owed one must match
         if (rsp_valid && rsp_ready) begin
            if (exp_data.size() == 0) begin
               fail_run("a response arrived while none was owed");
            end
            expect_flag("rsp_write", rsp_write, exp_write.pop_front());
            check_status("rsp_status", rsp_status, exp_status.pop_front());
            compare_data("rsp_data", rsp_data, exp_data.pop_front());
            verify_id("rsp_src_id", rsp_src_id, exp_src.pop_front());
            verify_id("rsp_dest_id", rsp_dest_id, exp_dest.pop_front());
            rsp_count++;
         end
         if (cmd_valid && cmd_ready) begin
            // writes with no byte lane enabled leave the shadow alone
            if (cmd_write && cmd_byteen != '0) begin
               shadow_mem[word_of(cmd_addr)] =
                  merge_bytes(shadow_word(cmd_addr), cmd_data, cmd_byteen);
            end
            if (cmd_read || !cmd_posted) begin
               exp_write.push_back(cmd_write);
               exp_src.push_back(cmd_dest_id);
               exp_dest.push_back(cmd_src_id);
               if (cmd_read && cmd_byteen != '0) begin
                  exp_data.push_back(shadow_word(cmd_addr));
                  exp_status.push_back(cmd_addr[31] ? RESP_SLVERR : RESP_OKAY);
               end else begin
                  exp_data.push_back(32'h0);
                  exp_status.push_back(RESP_OKAY);
               end
            end
         end
         if (avm_read || avm_write) begin
            if (cmd_byteen == '0) begin
               fail_run("the slave saw a command with all byte enables zero");
            end
            match_addr("avm_address", avm_address, word_of(cmd_addr));
         end
         p2_valid  = p1_valid;
         p2_data   = p1_data;
         p2_status = p1_status;
         p1_valid  = 1'b0;
         if (avm_write && !avm_waitrequest) begin
            compare_data("avm_writedata", avm_writedata, cmd_data);
            slave_mem[word_of(avm_address)] =
               merge_bytes(slave_word(avm_address), avm_writedata, avm_byteenable);
         end
         // the slave flags the upper half of the address space as an error
         if (avm_read && !avm_waitrequest) begin
            p1_valid  = 1'b1;
            p1_data   = slave_word(avm_address);
            p1_status = avm_address[31] ? RESP_SLVERR : RESP_OKAY;
         end
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int owed;
      int pass;
      reset         = 1'b1;
      cmd_valid     = 1'b0;
      cmd_write     = 1'b0;
      cmd_read      = 1'b0;
      cmd_posted    = 1'b0;
      cmd_addr      = '0;
      cmd_data      = '0;
      cmd_byteen    = '0;
      cmd_src_id    = '0;
      cmd_dest_id   = '0;
      stall_on      = 1'b0;
      wait_stall_en = 1'b0;
      rsp_stall_en  = 1'b0;
      load_commands();
      if (q_addr.size() == 0) begin
         fail_run("the test data holds no commands");
      end
      owed = 0;
      foreach (q_addr[i]) begin
         if (!q_write[i] || !q_posted[i]) begin
            owed++;
         end
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // the first pass runs without stalls and the second with the enabled ones
      for (pass = 0; pass < 2; pass++) begin
         foreach (q_addr[i]) begin
            send_command(i);
         end
         @(negedge clk);
         cmd_valid = 1'b0;
         wait_drain();
         // every owed answer has left, so the agent must offer nothing more
         expect_flag("rsp_valid", rsp_valid, 1'b0);
         if (pass == 0) begin
            @(posedge clk);
            stall_on = 1'b1;
            @(negedge clk);
         end
      end
      foreach (shadow_mem[a]) begin
         compare_data($sformatf("memory word 0x%h", a), slave_word(a), shadow_mem[a]);
      end
      if (rsp_count != 2 * owed) begin
         fail_run($sformatf("%0d responses arrived but %0d were owed", rsp_count, 2 * owed));
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* all.f */
verilog/slave_agent_pkg.sv
verilog/sync_fifo.sv
verilog/command_issuer.sv
verilog/response_builder.sv
verilog/slave_agent_top.sv
verification/slave_agent_asserts.sv
verification/tb_slave_agent.sv

/* Makefile */
TOP = tb_slave_agent

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* verification/slave_agent_testdata.txt */
# header line: waitrequest stall enable, rsp_ready stall enable (used on the second pass)
# command lines: kind (1 write, 0 read) posted addr data byteen src_id dest_id, all in hex
1 1
1 0 00000010 11223344 f 1 2
1 1 00000014 a5a5a5a5 f 3 4
1 0 00000011 0000cc00 2 2 5
1 1 00000012 00ee0000 4 6 1
0 0 00000010 00000000 f 1 2
0 0 00000014 00000000 f 4 3
0 0 00000013 00000000 f 5 6
1 0 00000020 deadbeef 0 2 3
0 0 00000020 00000000 f 2 3
0 0 00000024 00000000 0 7 0
0 0 80000040 00000000 f 1 1
1 1 80000044 12345678 f 0 7
0 0 80000044 00000000 3 0 7
1 0 00000031 cafef00d 3 3 3
0 0 00000030 00000000 f 6 2
0 0 00000034 00000000 f 2 6
0 0 00000038 00000000 1 4 4
